// File: baudRateGen.sv
/*
  baud generator
  bitTick fires once per programmed bit time, sampleTick at 1/16 of it
  sample counter is realigned on every bitTick so each bit gets 16 samples
  restart reloads both counters after a rate write
*/
`timescale 1ns/1ns
`default_nettype none

`include "uart_config.svh"

module baudRateGen (
  input wire clk,
  input wire nReset,
  input wire uartPkg::bitTime rate,
  input wire restart,
  output logic bitTick,
  output logic sampleTick
);
  import uartPkg::*;

  localparam int sampleShift = $clog2(`UART_OVERSAMPLE);

  bitTime bitCnt;      // counts down to the next bit edge
  bitTime sampleCnt;   // counts down to the next sample
  bitTime sampleRate;  // clocks per sample, remainder dropped

  assign sampleRate = rate >> sampleShift;

  assign bitTick = (bitCnt == '0);
  assign sampleTick = (sampleCnt == '0);

  always_ff @(posedge clk, negedge nReset) begin
    if (!nReset) begin
      bitCnt <= bitTime'(`UART_DEFAULT_RATE - 1);
      sampleCnt <= bitTime'((`UART_DEFAULT_RATE >> sampleShift) - 1);
    end else if (restart) begin
      bitCnt <= rate - bitTime'(1);        // new rate already in the register
      sampleCnt <= sampleRate - bitTime'(1);
    end else begin
      bitCnt <= bitTick ? rate - bitTime'(1) : bitCnt - bitTime'(1);
      // realign samples to the bit period
      if (bitTick || sampleTick) begin
        sampleCnt <= sampleRate - bitTime'(1);
      end else begin
        sampleCnt <= sampleCnt - bitTime'(1);
      end
    end
  end

endmodule

`default_nettype wire

// File: byteFifo.sv
/*
  byte FIFO, UART_FIFO_DEPTH entries, circular buffer
  pointers carry one extra bit to tell full from empty
  push and pop in one cycle are both honoured, even when full
  a dropped push sets a sticky overflow, which only clear removes
*/
`timescale 1ns/1ns
`default_nettype none

`include "uart_config.svh"

module byteFifo (
  input wire clk,
  input wire nReset,
  input wire push,
  input wire uartPkg::uartByte pushData,
  input wire pop,
  input wire clear,
  output uartPkg::uartByte head,
  output uartPkg::fifoCount count,
  output logic full,
  output logic empty,
  output logic overflow
);
  import uartPkg::*;

  localparam int ptrW = $clog2(`UART_FIFO_DEPTH);

  uartByte mem [`UART_FIFO_DEPTH];
  logic [ptrW:0] wrPtr;  // msb is the wrap bit
  logic [ptrW:0] rdPtr;
  logic doPush;
  logic doPop;

  assign empty = (wrPtr == rdPtr);
  assign full = (wrPtr[ptrW] != rdPtr[ptrW]) && (wrPtr[ptrW-1:0] == rdPtr[ptrW-1:0]);
  assign count = fifoCount'(wrPtr - rdPtr);
  assign head = mem[rdPtr[ptrW-1:0]];  // show-ahead

  assign doPop = pop && !empty;          // pop on empty ignored
  assign doPush = push && (!full || doPop); // pop frees the slot same cycle

  always_ff @(posedge clk, negedge nReset) begin
    if (!nReset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      overflow <= 1'b0;
    end else if (clear) begin
      wrPtr <= '0;  // contents left as they are
      rdPtr <= '0;
      overflow <= 1'b0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      if (push && !doPush) begin
        overflow <= 1'b1;  // byte lost
      end
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr[ptrW-1:0]] <= pushData;
    end
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
uartPkg.sv
baudRateGen.sv
byteFifo.sv
uartReceiver.sv
uartTransmitter.sv
uartRegisters.sv
uartPeripheral.sv
uartTb.sv

// File: uartPeripheral.sv
/*
  uart peripheral top level
  register bus and serial pins in, wiring between register block,
  both FIFOs, baud generator, receiver and transmitter
*/
`timescale 1ns/1ns
`default_nettype none

module uartPeripheral (
  input wire clk,
  input wire nReset,
  input wire uartPkg::busAddr addr,
  input wire wen,
  input wire ren,
  input wire uartPkg::busWord wdata,
  output uartPkg::busWord rdata,
  output logic error,
  input wire rx,
  output logic tx,
  input wire cts,
  output logic rts
);
  import uartPkg::*;

  uartByte txPushData, txHead, txByte;
  uartByte rxHead, rxData;
  fifoCount txCount, rxCount;
  bitTime rate;
  logic txPush, txPop, rxPop, clear;
  logic restart, txStart, txBusy;
  logic rxDone, frameErr, rxOverflow;
  logic bitTick, sampleTick;

  uartRegisters regs (
    .clk, .nReset, .addr, .wen, .ren, .wdata, .rdata, .error, .cts,
    .txPush, .txPushData, .txPop, .txHead, .txCount,
    .rxPop, .rxHead, .rxCount, .rxOverflow,
    .clear, .rate, .restart, .txStart, .txByte, .txBusy, .frameErr, .rts
  );

  // tx path fill is limited by the register block, so full/overflow are unused
  byteFifo txFifo (
    .clk, .nReset,
    .push(txPush), .pushData(txPushData), .pop(txPop), .clear,
    .head(txHead), .count(txCount), .full(), .empty(), .overflow()
  );

  byteFifo rxFifo (
    .clk, .nReset,
    .push(rxDone), .pushData(rxData), .pop(rxPop), .clear,
    .head(rxHead), .count(rxCount), .full(), .empty(), .overflow(rxOverflow)
  );

  baudRateGen baud (
    .clk, .nReset, .rate, .restart, .bitTick, .sampleTick
  );

  uartReceiver receiver (
    .clk, .nReset, .sampleTick, .rx, .data(rxData), .done(rxDone), .frameErr
  );

  uartTransmitter transmitter (
    .clk, .nReset, .bitTick, .start(txStart), .data(txByte), .tx, .busy(txBusy)
  );

endmodule

`default_nettype wire

// File: uartPkg.sv
/*
  shared types for the uart peripheral
  modules name these types in their port lists and import the package inside
  the FSM enums carry RX_ and TX_ prefixes so both fit in one scope
*/
`default_nettype none

`include "uart_config.svh"

package uartPkg;

  typedef logic [7:0] uartByte;                     // serial payload
  typedef logic [`UART_BUS_WIDTH-1:0] busWord;      // register data
  typedef logic [7:0] busAddr;                      // register byte address
  typedef logic [15:0] bitTime;                     // clocks per bit
  typedef logic [3:0] fifoCount;                    // 0..8 entries
  typedef logic [3:0] sampleCount;                  // oversample position

  // receiver FSM
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,  // waiting for start midpoint
    RX_DATA,
    RX_STOP
  } rxState;

  // transmitter FSM
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,  // byte latched, start bit pending next tick
    TX_DATA,
    TX_STOP
  } txState;

endpackage

`default_nettype wire

// File: uartReceiver.sv
/*
  8N1 serial receiver, 16x oversampled from sampleTick
  falling edge in idle starts a frame, start bit is rechecked at its midpoint
  data bits are taken LSB first at mid-bit
  stop midpoint gives done for a high line, frameErr for a low one
*/
`timescale 1ns/1ns
`default_nettype none

`include "uart_config.svh"

module uartReceiver (
  input wire clk,
  input wire nReset,
  input wire sampleTick,
  input wire rx,
  output uartPkg::uartByte data,
  output logic done,
  output logic frameErr
);
  import uartPkg::*;

  localparam sampleCount halfCnt = sampleCount'(`UART_OVERSAMPLE / 2 - 1);
  localparam sampleCount fullCnt = sampleCount'(`UART_OVERSAMPLE - 1);

  rxState state;
  logic [2:0] rxSync;    // two sync stages plus edge history
  logic rxIn;
  logic fall;
  sampleCount sampleCnt;
  logic [2:0] bitIdx;    // data bit being received
  logic bitMid;

  assign rxIn = rxSync[1];
  assign fall = rxSync[2] && !rxSync[1];
  assign bitMid = sampleTick && (sampleCnt == fullCnt);

  always_ff @(posedge clk, negedge nReset) begin
    if (!nReset) begin
      rxSync <= 3'b111;  // line idles high
      state <= RX_IDLE;
      sampleCnt <= '0;
      bitIdx <= '0;
      done <= 1'b0;
      frameErr <= 1'b0;
    end else begin
      rxSync <= {rxSync[1:0], rx};
      done <= 1'b0;
      frameErr <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (fall) begin
            state <= RX_START;
            sampleCnt <= '0;
          end
        end
        RX_START: begin
          if (sampleTick) begin
            if (sampleCnt == halfCnt) begin
              // glitch if line went back high
              state <= rxIn ? RX_IDLE : RX_DATA;
              sampleCnt <= '0;
              bitIdx <= '0;
            end else begin
              sampleCnt <= sampleCnt + 4'd1;
            end
          end
        end
        RX_DATA: begin
          if (sampleTick) begin
            sampleCnt <= bitMid ? '0 : sampleCnt + 4'd1;
          end
          if (bitMid) begin
            bitIdx <= bitIdx + 3'd1;
            if (bitIdx == 3'd7) begin
              state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (sampleTick) begin
            sampleCnt <= bitMid ? '0 : sampleCnt + 4'd1;
          end
          if (bitMid) begin
            done <= rxIn;        // good stop bit
            frameErr <= !rxIn;   // byte discarded
            state <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // shift in at mid-bit, LSB arrives first
  always_ff @(posedge clk) begin
    if (state == RX_DATA && bitMid) begin
      data <= {rxIn, data[7:1]};
    end
  end

endmodule

`default_nettype wire

// File: uartRegisters.sv
/*
  register block for the uart peripheral
  decodes the bus, holds rate and flow control, builds the registered read word
  drives FIFO push/pop/clear, baud restart and the transmit launch
  frame errors are kept sticky here until RX_STATE is read
*/
`timescale 1ns/1ns
`default_nettype none

`include "uart_config.svh"

module uartRegisters (
  input wire clk,
  input wire nReset,
  input wire uartPkg::busAddr addr,
  input wire wen,
  input wire ren,
  input wire uartPkg::busWord wdata,
  output uartPkg::busWord rdata,
  output logic error,
  input wire cts,
  output logic txPush,
  output uartPkg::uartByte txPushData,
  output logic txPop,
  input wire uartPkg::uartByte txHead,
  input wire uartPkg::fifoCount txCount,
  output logic rxPop,
  input wire uartPkg::uartByte rxHead,
  input wire uartPkg::fifoCount rxCount,
  input wire rxOverflow,
  output logic clear,
  output uartPkg::bitTime rate,
  output logic restart,
  output logic txStart,
  output uartPkg::uartByte txByte,
  input wire txBusy,
  input wire frameErr,
  output logic rts
);
  import uartPkg::*;

  logic flowCtl;       // 1 = cts gates transmission
  logic frameErrFlag;  // sticky
  logic rxEmpty;
  logic launch;

  assign rxEmpty = (rxCount == '0);
  assign error = rxOverflow;
  assign rts = (rxCount == `UART_FIFO_DEPTH);  // receive FIFO full

  // bus side FIFO strobes act at the sampling edge
  assign txPush = wen && (addr == `UART_ADDR_TX_DATA) && (txCount != `UART_FIFO_DEPTH);
  assign txPushData = wdata[7:0];
  assign rxPop = ren && (addr == `UART_ADDR_RX_DATA) && !rxEmpty;
  assign clear = wen && (addr == `UART_ADDR_BUFFER_CLEAR);

  // txStart still high means the last launch hasn't reached busy yet
  assign launch = (txCount != '0) && !txBusy && !txStart && (cts || !flowCtl);

  always_ff @(posedge clk, negedge nReset) begin
    if (!nReset) begin
      rate <= `UART_DEFAULT_RATE;
      flowCtl <= 1'b1;
      restart <= 1'b0;
    end else begin
      restart <= wen && (addr == `UART_ADDR_BAUD_RATE);  // one cycle after new rate
      if (wen && addr == `UART_ADDR_BAUD_RATE) begin
        if (wdata[15:0] < `UART_MIN_RATE) begin
          rate <= bitTime'(`UART_MIN_RATE);  // clamp
        end else begin
          rate <= wdata[15:0];
        end
      end
      if (wen && addr == `UART_ADDR_FLOW_CONTROL) begin
        flowCtl <= wdata[0];
      end
    end
  end

  always_ff @(posedge clk, negedge nReset) begin
    if (!nReset) begin
      txStart <= 1'b0;
      txPop <= 1'b0;
    end else begin
      txStart <= launch;
      txPop <= launch;  // head leaves with the start pulse
    end
  end

  always_ff @(posedge clk) begin
    if (launch) begin
      txByte <= txHead;
    end
  end

  always_ff @(posedge clk, negedge nReset) begin
    if (!nReset) begin
      rdata <= '0;
      frameErrFlag <= 1'b0;
    end else begin
      if (frameErr) begin
        frameErrFlag <= 1'b1;  // new error wins over a clearing read
      end else if (ren && addr == `UART_ADDR_RX_STATE) begin
        frameErrFlag <= 1'b0;
      end
      if (ren) begin
        case (addr)
          `UART_ADDR_RX_DATA: rdata <= rxEmpty ? '0 : {24'b0, rxHead};
          `UART_ADDR_RX_STATE: begin
            rdata <= {25'b0, rxOverflow, frameErrFlag, !rxEmpty, rxCount};
          end
          `UART_ADDR_TX_STATE: rdata <= {rate, 11'b0, txBusy, txCount};
          `UART_ADDR_BAUD_RATE: rdata <= {16'b0, rate};
          `UART_ADDR_FLOW_CONTROL: rdata <= {31'b0, flowCtl};
          default: rdata <= '0;  // write-only or unmapped
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: uartTb.sv
/*
  testbench for the uart peripheral, top module uartTb
  drives the register bus and the rx line, decodes tx with a forked monitor
  expected bytes and status bits come from queue models kept here
  bit time is set to 32 clocks first so frames stay short
*/
`timescale 1ns/1ns
`default_nettype none

`include "uart_config.svh"

module uartTb;
  import uartPkg::*;

  localparam int bitCycles = 32;      // programmed bit time
  localparam int cycleLimit = 60000;  // about twice the summed frame time

  logic clk;
  logic nReset;
  busAddr addr;
  logic wen;
  logic ren;
  busWord wdata;
  busWord rdata;
  logic error;
  logic rx;
  logic tx;
  logic cts;
  logic rts;

  int errors = 0;
  int cycles = 0;
  logic [7:0] txModel[$];       // bytes still expected on tx
  logic [7:0] rxModel[$];       // what the rx FIFO should hold
  logic modelOverflow = 1'b0;   // sticky until buffer clear
  logic modelFrameErr = 1'b0;   // sticky until RX_STATE read

  uartPeripheral i_uartPeripheral (
    .clk, .nReset, .addr, .wen, .ren, .wdata, .rdata, .error, .rx, .tx, .cts, .rts
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("timeout: run did not finish within %0d clock cycles", cycleLimit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic writeReg(input busAddr a, input busWord d);
    @(posedge clk);
    addr <= a;
    wdata <= d;
    wen <= 1'b1;
    @(posedge clk);
    wen <= 1'b0;
  endtask

  // rdata settles at the edge after ren is sampled, taken at the negedge
  task automatic readReg(input busAddr a, output busWord d);
    @(posedge clk);
    addr <= a;
    ren <= 1'b1;
    @(posedge clk);
    ren <= 1'b0;
    @(negedge clk);
    d = rdata;
  endtask

  // 8N1 on rx, LSB first, badStop drives the stop bit low
  task automatic sendFrame(input logic [7:0] b, input logic badStop);
    logic [9:0] frame;
    frame = {!badStop, b, 1'b0};  // start bit goes out first
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      rx <= frame[i];
      repeat (bitCycles - 1) @(posedge clk);
    end
    @(posedge clk);
    rx <= 1'b1;  // idle again
    if (badStop) begin
      modelFrameErr = 1'b1;  // byte discarded
    end else if (rxModel.size() == `UART_FIFO_DEPTH) begin
      modelOverflow = 1'b1;
    end else begin
      rxModel.push_back(b);
    end
  endtask

  task automatic checkRxState();
    busWord w;
    busWord expected;
    expected = {25'b0, modelOverflow, modelFrameErr, rxModel.size() != 0,
                fifoCount'(rxModel.size())};
    readReg(`UART_ADDR_RX_STATE, w);
    checkValue("RX_STATE", expected, w);
    modelFrameErr = 1'b0;  // cleared by this read
  endtask

  task automatic readRxByte();
    busWord w;
    busWord expected;
    expected = '0;  // empty FIFO reads as zero
    if (rxModel.size() != 0) begin
      expected = {24'b0, rxModel.pop_front()};
    end
    readReg(`UART_ADDR_RX_DATA, w);
    checkValue("RX_DATA", expected, w);
  endtask

  task automatic writeTxByte(input logic [7:0] b);
    writeReg(`UART_ADDR_TX_DATA, {24'b0, b});
    txModel.push_back(b);
  endtask

  // all expected frames seen, then let the last stop bit finish
  task automatic drainTx();
    while (txModel.size() != 0) @(negedge clk);
    repeat (bitCycles) @(negedge clk);
  endtask

  // decodes tx frames at mid-bit and checks them against txModel
  task automatic monitorTx();
    logic [7:0] b;
    forever begin
      @(negedge clk);
      if (tx === 1'b0) begin
        repeat (bitCycles / 2) @(negedge clk);  // middle of start bit
        if (tx !== 1'b0) begin
          errors++;
          $display("tx start bit did not stay low until its midpoint at %0t", $time);
        end
        for (int i = 0; i < 8; i++) begin
          repeat (bitCycles) @(negedge clk);
          b[i] = tx;
        end
        repeat (bitCycles) @(negedge clk);
        checkValue("tx stop bit", 1, tx);
        if (txModel.size() == 0) begin
          errors++;
          $display("a frame with data %h appeared on tx with no byte pending", b);
        end else begin
          checkValue("tx data", txModel.pop_front(), b);
        end
      end
    end
  endtask

  initial begin
    busWord w;
    int unsigned seed;
    int unsigned gap;
    int stallLow;
    seed = 32'hdb288c13;
    gap = $urandom(seed);  // seeds the generator once
    nReset <= 1'b0;
    addr <= '0;
    wen <= 1'b0;
    ren <= 1'b0;
    wdata <= '0;
    rx <= 1'b1;
    cts <= 1'b1;
    repeat (16) @(posedge clk);
    nReset <= 1'b1;
    fork
      monitorTx();
    join_none

    writeReg(`UART_ADDR_BAUD_RATE, bitCycles);
    readReg(`UART_ADDR_BAUD_RATE, w);
    checkValue("BAUD_RATE", bitCycles, w);

    // transmit path, flow control off so a low cts must not hold it back
    @(posedge clk);
    cts <= 1'b0;
    writeReg(`UART_ADDR_FLOW_CONTROL, 0);
    for (int n = 0; n < 20; n++) begin
      readReg(`UART_ADDR_TX_STATE, w);
      while (w[3:0] == `UART_FIFO_DEPTH) readReg(`UART_ADDR_TX_STATE, w);
      writeTxByte(8'($urandom));
    end
    drainTx();

    // receive path with random gaps
    for (int n = 0; n < 30; n++) begin
      gap = $urandom % 40;
      repeat (gap) @(posedge clk);
      sendFrame(8'($urandom), 1'b0);
      repeat (2 * bitCycles) @(posedge clk);
      checkRxState();
      readRxByte();
    end

    // flow control, cts low stalls the queue
    @(posedge clk);
    cts <= 1'b0;
    writeReg(`UART_ADDR_FLOW_CONTROL, 1);
    repeat (3) writeTxByte(8'($urandom));
    stallLow = 0;
    repeat (30 * bitCycles) begin
      @(negedge clk);
      if (tx !== 1'b1) stallLow++;
    end
    checkValue("tx low cycles during cts stall", 0, stallLow);
    readReg(`UART_ADDR_TX_STATE, w);
    checkValue("TX_STATE", {16'(bitCycles), 11'b0, 1'b0, 4'd3}, w);  // rate, busy, count
    @(posedge clk);
    cts <= 1'b1;
    drainTx();

    // nine frames into an 8-entry FIFO
    repeat (8) sendFrame(8'($urandom), 1'b0);
    repeat (2 * bitCycles) @(posedge clk);
    @(negedge clk);
    checkValue("rts", 1, rts);
    sendFrame(8'($urandom), 1'b0);
    repeat (2 * bitCycles) @(posedge clk);
    @(negedge clk);
    checkValue("error", 1, error);
    checkRxState();
    repeat (9) readRxByte();  // last one finds it empty

    // low stop bit
    sendFrame(8'($urandom), 1'b1);
    repeat (2 * bitCycles) @(posedge clk);
    checkRxState();
    checkRxState();  // flag gone after one read

    // buffer clear with both FIFOs partly filled, overflow still set
    repeat (2) sendFrame(8'($urandom), 1'b0);
    repeat (2 * bitCycles) @(posedge clk);
    @(posedge clk);
    cts <= 1'b0;
    repeat (3) writeTxByte(8'($urandom));
    writeReg(`UART_ADDR_BUFFER_CLEAR, 0);
    rxModel.delete();
    txModel.delete();
    modelOverflow = 1'b0;
    checkRxState();
    readReg(`UART_ADDR_TX_STATE, w);
    checkValue("TX_STATE count", 0, w[3:0]);
    @(negedge clk);
    checkValue("error", 0, error);
    checkValue("rts", 0, rts);

    repeat (bitCycles) @(posedge clk);
    $display("run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: uartTransmitter.sv
/*
  8N1 serial transmitter
  start latches the byte and raises busy, the frame begins at the next bitTick
  start bit, 8 data bits LSB first and stop bit each last one tick period
  tx is a flop and rests high
*/
`timescale 1ns/1ns
`default_nettype none

module uartTransmitter (
  input wire clk,
  input wire nReset,
  input wire bitTick,
  input wire start,
  input wire uartPkg::uartByte data,
  output logic tx,
  output logic busy
);
  import uartPkg::*;

  txState state;
  uartByte shiftReg;     // remaining data bits
  logic [3:0] bitCnt;    // 0..7 data, 8..9 stop

  always_ff @(posedge clk, negedge nReset) begin
    if (!nReset) begin
      state <= TX_IDLE;
      tx <= 1'b1;
      busy <= 1'b0;
      bitCnt <= '0;
    end else begin
      case (state)
        TX_IDLE: begin
          if (start) begin
            busy <= 1'b1;
            state <= TX_START;
          end
        end
        TX_START: begin
          if (bitTick) begin
            tx <= 1'b0;  // start bit
            bitCnt <= '0;
            state <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (bitTick) begin
            tx <= shiftReg[0];
            bitCnt <= bitCnt + 4'd1;
            if (bitCnt == 4'd7) begin
              state <= TX_STOP;
            end
          end
        end
        TX_STOP: begin
          if (bitTick) begin
            tx <= 1'b1;  // stop bit, then idle level
            bitCnt <= bitCnt + 4'd1;
            if (bitCnt == 4'd9) begin
              busy <= 1'b0;  // stop bit has run a full period
              state <= TX_IDLE;
            end
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == TX_IDLE && start) begin
      shiftReg <= data;
    end else if (state == TX_DATA && bitTick) begin
      shiftReg <= shiftReg >> 1;
    end
  end

endmodule

`default_nettype wire

// File: uart_config.svh
/*
  uart peripheral configuration constants
  include wherever FIFO depth, oversampling, rates or register offsets are needed
  the guard makes repeated includes safe
*/
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

`define UART_FIFO_DEPTH 8      // entries per FIFO, count field is 4 bits
`define UART_OVERSAMPLE 16     // receiver samples per bit
`define UART_DEFAULT_RATE 5207 // bit time in clocks after reset
`define UART_MIN_RATE 32       // smaller writes are raised to this
`define UART_BUS_WIDTH 32

// register byte offsets
`define UART_ADDR_RX_DATA 8'd0
`define UART_ADDR_TX_DATA 8'd4
`define UART_ADDR_RX_STATE 8'd8
`define UART_ADDR_TX_STATE 8'd12
`define UART_ADDR_BAUD_RATE 8'd16
`define UART_ADDR_BUFFER_CLEAR 8'd20
`define UART_ADDR_FLOW_CONTROL 8'd24

`endif
